// ==== Bender.yml ====
package:
  name: coco_glue

sources:
  - dragon_pkg.sv
  - bus_decode.sv
  - image_loader.sv
  - disk_latch.sv
  - joystick_pad.sv
  - coco_glue.sv
  - target: simulation
    files:
      - tb_coco_glue.sv

// ==== build.f ====
dragon_pkg.sv
bus_decode.sv
image_loader.sv
disk_latch.sv
joystick_pad.sv
coco_glue.sv
tb_coco_glue.sv

// ==== bus_decode.sv ====
// combinational decode of the SAM select; cpu_din and rom address are valid in the same cycle
`timescale 1ns/10ps

module bus_decode (
	input  dragon_pkg::machine_t  machine,
	input  dragon_pkg::dev_sel_t  device_select,
	input  dragon_pkg::addr_t     cpu_addr,
	input  logic                  clk_e,
	input  logic                  ddrb2,
	input  logic                  portb2,
	input  logic                  cart_loaded,
	input  logic                  disk_cart_enabled,
	input  dragon_pkg::byte_t     ext_rom_din,
	input  dragon_pkg::byte_t     ext_ram_din,
	input  dragon_pkg::byte_t     pia_dout,
	input  dragon_pkg::byte_t     pia1_dout,
	input  dragon_pkg::byte_t     acia_dout,
	input  dragon_pkg::byte_t     fdc_dout,
	output dragon_pkg::byte_t     cpu_din,
	output dragon_pkg::rom_addr_t ext_rom_addr,
	output logic                  ext_rom_rd,
	output logic                  pia_cs,
	output logic                  pia1_cs,
	output logic                  acia_cs,
	output logic                  io_sel
);
	import dragon_pkg::*;

	logic      acia_win; // upper half of the pia window on the dragon 64
	logic      bank1;
	logic      rom_win;
	rom_page_t page;

	assign acia_win = (machine == mach_dragon64) & cpu_addr[2];
	// port b2 floats high through a pull-up when ddrb2 is an input
	assign bank1 = ~ddrb2 | portb2;

	assign pia_cs  = (device_select == dev_pia0) & ~acia_win;
	assign acia_cs = (device_select == dev_pia0) & acia_win;
	assign pia1_cs = (device_select == dev_pia1);
	assign io_sel  = (device_select == dev_io);

	assign rom_win = (device_select == dev_rom8) | (device_select == dev_roma)
		| (device_select == dev_romc);

	always_comb begin
		page = PAGE_COCO_BASIC;
		case (device_select)
			dev_rom8: begin
				case (machine)
					mach_dragon32: page = PAGE_D32_EXT;
					mach_dragon64: page = bank1 ? PAGE_D64_EXT1 : PAGE_D64_EXT2;
					default:       page = PAGE_COCO_EXT;
				endcase
			end
			dev_roma: begin
				case (machine)
					mach_dragon32: page = PAGE_D32_BASIC;
					mach_dragon64: page = bank1 ? PAGE_D64_BASIC1 : PAGE_D64_BASIC2;
					default:       page = PAGE_COCO_BASIC;
				endcase
			end
			dev_romc: begin
				if (cart_loaded)
					page = {PAGE_CART_BASE[3:1], cpu_addr[13]}; // 16k cartridge
				else if (machine == mach_coco)
					page = PAGE_COCO_DISK;
				else
					page = PAGE_D_DISK;
			end
			default: ;
		endcase
	end

	assign ext_rom_addr = {3'd0, page, cpu_addr[12:0]};
	assign ext_rom_rd   = clk_e & rom_win;

	always_comb begin
		case (device_select)
			dev_ram:            cpu_din = ext_ram_din;
			dev_rom8, dev_roma: cpu_din = ext_rom_din;
			dev_romc:           cpu_din = (cart_loaded | disk_cart_enabled) ? ext_rom_din : OPEN_BUS;
			dev_pia0:           cpu_din = acia_win ? acia_dout : pia_dout;
			dev_pia1:           cpu_din = pia1_dout;
			dev_io:             cpu_din = fdc_dout;
			default:            cpu_din = OPEN_BUS;
		endcase
	end

	// sampled on each cpu cycle
	a_one_cs: assert property (@(posedge clk_e) $onehot0({pia_cs, pia1_cs, acia_cs, io_sel}))
		else $error("more than one chip select active");

endmodule

// ==== coco_glue.sv ====
// memory and i/o glue top; external memory path only, cpu and peripherals live outside
`timescale 1ns/10ps

module coco_glue (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  dragon,
	input  logic                  mem64kb,
	input  dragon_pkg::addr_t     cpu_addr,
	input  logic                  cpu_rw,
	input  dragon_pkg::byte_t     cpu_dout,
	input  logic                  clk_e,
	input  dragon_pkg::dev_sel_t  device_select,
	input  dragon_pkg::addr_t     sam_a,
	input  logic                  sam_we_n,
	input  logic                  ddrb2,
	input  logic                  portb2,
	input  dragon_pkg::byte_t     ext_rom_din,
	input  dragon_pkg::byte_t     ext_ram_din,
	input  dragon_pkg::byte_t     pia_dout,
	input  dragon_pkg::byte_t     pia1_dout,
	input  dragon_pkg::byte_t     acia_dout,
	input  dragon_pkg::byte_t     fdc_dout,
	input  dragon_pkg::byte_t     ioctl_data,
	input  dragon_pkg::dl_addr_t  ioctl_addr,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic                  ioctl_cart,
	input  logic                  ioctl_rom,
	input  logic                  hard_reset,
	input  logic                  cart_remove,
	input  logic                  disk_cart_enabled,
	input  logic                  fdc_irq,
	input  logic                  fdc_drq,
	input  logic [3:0]            joy1,
	input  logic [3:0]            joy2,
	input  dragon_pkg::joy_axis_t joya1,
	input  dragon_pkg::joy_axis_t joya2,
	input  logic                  joy_use_dpad,
	output dragon_pkg::byte_t     cpu_din,
	output dragon_pkg::rom_addr_t ext_rom_addr,
	output logic                  ext_rom_rd,
	output logic                  pia_cs,
	output logic                  pia1_cs,
	output logic                  acia_cs,
	output logic                  io_sel,
	output dragon_pkg::ram_addr_t ext_ram_addr,
	output dragon_pkg::byte_t     ext_ram_dout,
	output logic                  ext_ram_wr,
	output logic                  cart_loaded,
	output logic                  fdc_sel,
	output logic [3:0]            fdc_drive_sel,
	output logic                  fdc_motor,
	output logic                  fdc_dden,
	output logic                  fdc_precomp,
	output logic                  nmi,
	output logic                  halt,
	output dragon_pkg::joy_axis_t dac_joya1,
	output dragon_pkg::joy_axis_t dac_joya2,
	output logic                  ledb
);
	import dragon_pkg::*;

	machine_t machine;

	// mem64kb only matters on the dragon
	assign machine = !dragon ? mach_coco : (mem64kb ? mach_dragon64 : mach_dragon32);

	assign ledb = ~(ioctl_download | fdc_motor); // active low

	bus_decode u_bus_decode (
		.machine(machine), .device_select(device_select), .cpu_addr(cpu_addr),
		.clk_e(clk_e), .ddrb2(ddrb2), .portb2(portb2), .cart_loaded(cart_loaded),
		.disk_cart_enabled(disk_cart_enabled), .ext_rom_din(ext_rom_din),
		.ext_ram_din(ext_ram_din), .pia_dout(pia_dout), .pia1_dout(pia1_dout),
		.acia_dout(acia_dout), .fdc_dout(fdc_dout), .cpu_din(cpu_din),
		.ext_rom_addr(ext_rom_addr), .ext_rom_rd(ext_rom_rd), .pia_cs(pia_cs),
		.pia1_cs(pia1_cs), .acia_cs(acia_cs), .io_sel(io_sel)
	);

	image_loader u_image_loader (
		.clk(clk), .reset_n(reset_n), .hard_reset(hard_reset),
		.ioctl_data(ioctl_data), .ioctl_addr(ioctl_addr),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_cart(ioctl_cart),
		.ioctl_rom(ioctl_rom), .cart_remove(cart_remove), .sam_a(sam_a),
		.sam_we_n(sam_we_n), .clk_e(clk_e), .cpu_dout(cpu_dout),
		.ext_ram_addr(ext_ram_addr), .ext_ram_dout(ext_ram_dout),
		.ext_ram_wr(ext_ram_wr), .cart_loaded(cart_loaded)
	);

	disk_latch u_disk_latch (
		.clk(clk), .reset_n(reset_n), .dragon(dragon),
		.disk_cart_enabled(disk_cart_enabled), .clk_e(clk_e), .io_sel(io_sel),
		.cpu_rw(cpu_rw), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
		.fdc_irq(fdc_irq), .fdc_drq(fdc_drq), .fdc_sel(fdc_sel),
		.fdc_drive_sel(fdc_drive_sel), .fdc_motor(fdc_motor), .fdc_dden(fdc_dden),
		.fdc_precomp(fdc_precomp), .nmi(nmi), .halt(halt)
	);

	joystick_pad u_joystick_pad (
		.clk(clk), .joy_use_dpad(joy_use_dpad), .joy1(joy1), .joy2(joy2),
		.joya1(joya1), .joya2(joya2), .dac_joya1(dac_joya1), .dac_joya2(dac_joya2)
	);

endmodule

// ==== coco_glue_testdata.txt ====
# tst cyc mode(dragon,64k) dsel addr dout flags ioaddr joy(j2,j1) joya1 chk | expected:
# din rom_addr ram_addr ram_dout status mask dac1 dac2  (chk: din,rom,ram,rdout,status,dac)
1 0 0 1 0123 00 203 00000 00 0000 12 00 02123 00000 00 00001 00001 0000 0000
1 0 0 2 0123 00 203 00000 00 0000 12 00 00123 00000 00 00001 00001 0000 0000
1 0 0 3 0123 00 203 00000 00 0000 12 00 04123 00000 00 00001 00001 0000 0000
1 0 2 1 0123 00 203 00000 00 0000 12 00 06123 00000 00 00001 00001 0000 0000
1 0 2 2 0123 00 203 00000 00 0000 12 00 08123 00000 00 00001 00001 0000 0000
1 0 2 3 0123 00 203 00000 00 0000 12 00 12123 00000 00 00001 00001 0000 0000
1 0 3 1 0123 00 203 00000 00 0000 12 00 0a123 00000 00 00001 00001 0000 0000
1 0 3 2 0123 00 203 00000 00 0000 12 00 0c123 00000 00 00001 00001 0000 0000
1 0 3 1 0123 00 207 00000 00 0000 12 00 0e123 00000 00 00001 00001 0000 0000
1 0 3 2 0123 00 207 00000 00 0000 12 00 10123 00000 00 00001 00001 0000 0000
1 0 3 1 0123 00 20f 00000 00 0000 12 00 0a123 00000 00 00001 00001 0000 0000
1 0 0 1 0123 00 202 00000 00 0000 12 00 02123 00000 00 00000 00001 0000 0000
2 0 0 0 0123 00 203 00000 00 0000 11 b2 00000 00000 00 00000 0001e 0000 0000
2 0 0 4 0123 00 203 00000 00 0000 11 c3 00000 00000 00 00002 0001e 0000 0000
2 0 3 4 0124 00 203 00000 00 0000 11 e5 00000 00000 00 00008 0001e 0000 0000
2 0 0 5 0123 00 203 00000 00 0000 11 d4 00000 00000 00 00004 0001e 0000 0000
2 0 0 6 0123 00 203 00000 00 0000 11 f6 00000 00000 00 00010 0001e 0000 0000
2 0 0 7 0123 00 203 00000 00 0000 11 ff 00000 00000 00 00000 0001e 0000 0000
2 0 0 3 0123 00 203 00000 00 0000 11 ff 00000 00000 00 00000 0001e 0000 0000
2 0 0 3 0123 00 213 00000 00 0000 11 a1 00000 00000 00 00000 0001e 0000 0000
3 1 0 3 2123 00 1603 00200 00 0000 12 00 1e123 00000 00 00041 00041 0000 0000
3 1 0 3 2123 00 1603 00080 00 0000 12 00 04123 00000 00 00001 00041 0000 0000
3 1 0 3 2123 00 1603 00200 00 0000 12 00 1e123 00000 00 00041 00041 0000 0000
3 1 0 3 2123 00 303 00000 00 0000 12 00 04123 00000 00 00001 00041 0000 0000
4 1 0 0 0000 5a 2e02 01234 00 0000 1c 00 00000 01234 5a 00020 00020 0000 0000
4 6 0 0 0000 5a 2602 01234 00 0000 1c 00 00000 01234 5a 00020 00020 0000 0000
4 1 0 0 0000 5a 2602 01234 00 0000 10 00 00000 00000 00 00020 00020 0000 0000
4 1 0 0 0000 5a 2602 01234 00 0000 10 00 00000 00000 00 00000 00020 0000 0000
4 1 0 0 0000 66 1e02 02345 00 0000 1c 00 00000 1e345 66 00020 00020 0000 0000
4 0 0 0 0456 3c 283 00000 00 0000 1c 00 00000 80071 00 00020 00020 0000 0000
4 0 0 0 0456 3c 282 00000 00 0000 10 00 00000 00000 00 00000 00020 0000 0000
4 0 0 0 0456 3c 003 00000 00 0000 1c 00 00000 80456 3c 00020 00020 0000 0000
4 0 0 0 0456 3c 203 00000 00 0000 10 00 00000 00000 00 00000 00020 0000 0000
5 1 0 6 ff40 a9 211 00000 00 0000 10 00 00000 00000 00 05300 3ff80 0000 0000
5 0 0 6 ff40 00 252 00000 00 0000 10 00 00000 00000 00 04300 3ff80 0000 0000
5 0 0 6 ff40 00 232 00000 00 0000 10 00 00000 00000 00 05b00 3ff80 0000 0000
5 1 0 6 ff40 00 232 00000 00 0000 10 00 00000 00000 00 04b00 3ff80 0000 0000
5 0 0 6 ff48 00 213 00000 00 0000 10 00 00000 00000 00 04380 3ff80 0000 0000
5 1 2 6 ff48 2e 211 00000 00 0000 10 00 00000 00000 00 10300 3ff80 0000 0000
5 0 2 6 ff48 00 232 00000 00 0000 10 00 00000 00000 00 10b00 3ff80 0000 0000
5 0 2 6 ff40 00 213 00000 00 0000 10 00 00000 00000 00 10380 3ff80 0000 0000
5 0 2 6 ff44 00 213 00000 00 0000 10 00 00000 00000 00 10300 3ff80 0000 0000
5 1 2 6 ff48 00 211 00000 00 0000 10 00 00000 00000 00 06000 3ff80 0000 0000
6 1 0 0 0000 00 4202 00000 00 0000 20 00 00000 00000 00 00000 00000 8080 8080
6 1 0 0 0000 00 4202 00000 41 0000 20 00 00000 00000 00 00000 00000 ff80 80ff
6 1 0 0 0000 00 4202 00000 c3 0000 20 00 00000 00000 00 00000 00000 0080 8000
6 1 0 0 0000 00 4202 00000 5a 0000 20 00 00000 00000 00 00000 00000 0000 ffff
6 1 0 0 0000 00 202 00000 00 1234 20 00 00000 00000 00 00000 00000 1234 edcb

// ==== disk_latch.sv ====
// floppy control latch for the coco and dragon disk carts; halt is coco only
`timescale 1ns/10ps

module disk_latch (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              dragon,
	input  logic              disk_cart_enabled,
	input  logic              clk_e,
	input  logic              io_sel,
	input  logic              cpu_rw,
	input  dragon_pkg::addr_t cpu_addr,
	input  dragon_pkg::byte_t cpu_dout,
	input  logic              fdc_irq,
	input  logic              fdc_drq,
	output logic              fdc_sel,
	output logic [3:0]        fdc_drive_sel,
	output logic              fdc_motor,
	output logic              fdc_dden,
	output logic              fdc_precomp,
	output logic              nmi,
	output logic              halt
);
	import dragon_pkg::*;

	logic ctrl_wr;
	logic nmi_en; // dragon only
	logic halt_en; // coco only

	// latch is at a3=0 on the coco, a3=1 on the dragon; the fdc sits at the other half
	assign ctrl_wr = disk_cart_enabled & clk_e & io_sel & ~cpu_rw & (cpu_addr[3] == dragon);
	assign fdc_sel = disk_cart_enabled & clk_e & io_sel & (cpu_addr[3] ^ dragon)
		& (~dragon | ~cpu_addr[2]);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			fdc_drive_sel <= 4'b0000;
			fdc_motor     <= 1'b0;
			fdc_dden      <= 1'b0;
			fdc_precomp   <= 1'b0;
			nmi_en        <= 1'b0;
			halt_en       <= 1'b0;
		end else begin
			if (ctrl_wr) begin
				if (dragon) begin
					fdc_drive_sel <= 4'b0001 << cpu_dout[1:0];
					fdc_motor     <= cpu_dout[2];
					fdc_dden      <= cpu_dout[3];
					fdc_precomp   <= cpu_dout[4];
					nmi_en        <= cpu_dout[5];
				end else begin
					fdc_drive_sel <= {cpu_dout[6], cpu_dout[2:0]}; // bit 6 is drive 3
					fdc_motor     <= cpu_dout[3];
					fdc_precomp   <= cpu_dout[4];
					fdc_dden      <= cpu_dout[5];
					halt_en       <= cpu_dout[7];
				end
			end
			if (fdc_irq)
				halt_en <= 1'b0; // end of command releases the cpu
		end
	end

	assign nmi  = fdc_irq & (dragon ? nmi_en : fdc_dden);
	assign halt = halt_en & ~fdc_drq;

	a_no_dragon_halt: assert property (@(posedge clk) disable iff (!reset_n)
		dragon |-> !halt)
		else $error("halt raised in dragon mode");

endmodule

// ==== dragon_pkg.sv ====
// shared widths, rom page map and codes; page numbers assume 8k pages in a 20-bit external rom
package dragon_pkg;

	typedef logic [15:0] addr_t;     // cpu address
	typedef logic [7:0]  byte_t;
	typedef logic [19:0] rom_addr_t; // external rom
	typedef logic [19:0] ram_addr_t; // external ram
	typedef logic [16:0] dl_addr_t;  // download port address
	typedef logic [15:0] joy_axis_t; // x high byte, y low byte
	typedef logic [3:0]  rom_page_t;

	// SAM S2..S0 device select
	typedef enum logic [2:0] {
		dev_ram    = 3'd0,
		dev_rom8   = 3'd1,
		dev_roma   = 3'd2,
		dev_romc   = 3'd3,
		dev_pia0   = 3'd4,
		dev_pia1   = 3'd5,
		dev_io     = 3'd6,
		dev_unused = 3'd7
	} dev_sel_t;

	typedef enum logic [1:0] {
		mach_coco     = 2'd0,
		mach_dragon32 = 2'd1,
		mach_dragon64 = 2'd2
	} machine_t;

	localparam rom_page_t PAGE_COCO_BASIC = 4'd0;
	localparam rom_page_t PAGE_COCO_EXT   = 4'd1;
	localparam rom_page_t PAGE_COCO_DISK  = 4'd2;
	localparam rom_page_t PAGE_D32_EXT    = 4'd3;
	localparam rom_page_t PAGE_D32_BASIC  = 4'd4;
	localparam rom_page_t PAGE_D64_EXT1   = 4'd5;
	localparam rom_page_t PAGE_D64_BASIC1 = 4'd6;
	localparam rom_page_t PAGE_D64_EXT2   = 4'd7;
	localparam rom_page_t PAGE_D64_BASIC2 = 4'd8;
	localparam rom_page_t PAGE_D_DISK     = 4'd9;
	localparam rom_page_t PAGE_CART_BASE  = 4'd14; // 14 and 15, picked by a13

	localparam logic [3:0] RAM_WINDOW    = 4'h8;
	localparam addr_t      CLEAR_ADDR    = 16'h0071; // cleared while hard reset is held
	localparam dl_addr_t   CART_MIN_SIZE = 17'h00100;
	localparam int         WR_STRETCH    = 8;

	localparam byte_t AXIS_MIN = 8'd0;
	localparam byte_t AXIS_MID = 8'd128;
	localparam byte_t AXIS_MAX = 8'd255;
	localparam byte_t OPEN_BUS = 8'hff;

endpackage

// ==== image_loader.sv ====
// external ram muxing for downloads, hard reset clear and cpu writes; no ram read strobe here
`timescale 1ns/10ps

module image_loader (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  hard_reset,
	input  dragon_pkg::byte_t     ioctl_data,
	input  dragon_pkg::dl_addr_t  ioctl_addr,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic                  ioctl_cart,
	input  logic                  ioctl_rom,
	input  logic                  cart_remove,
	input  dragon_pkg::addr_t     sam_a,
	input  logic                  sam_we_n,
	input  logic                  clk_e,
	input  dragon_pkg::byte_t     cpu_dout,
	output dragon_pkg::ram_addr_t ext_ram_addr,
	output dragon_pkg::byte_t     ext_ram_dout,
	output logic                  ext_ram_wr,
	output logic                  cart_loaded
);
	import dragon_pkg::*;

	dl_addr_t              dl_a;
	addr_t                 cpu_a;
	logic [WR_STRETCH-1:0] dl_wr;         // write stretch, one bit per cycle
	logic                  cart_q = 1'b0; // no cartridge at power-up

	// cartridges sit in the top two rom pages
	assign dl_a  = ioctl_rom ? ioctl_addr : {PAGE_CART_BASE[3:1], ioctl_addr[13:0]};
	assign cpu_a = hard_reset ? CLEAR_ADDR : sam_a;

	assign ext_ram_addr = ioctl_download ? {3'd0, dl_a} : {RAM_WINDOW, cpu_a};
	assign ext_ram_dout = ioctl_download ? ioctl_data : (hard_reset ? 8'h00 : cpu_dout);

	always_ff @(posedge clk) begin
		if (!reset_n)
			dl_wr <= '0;
		else if (ioctl_wr)
			dl_wr <= '1;
		else
			dl_wr <= {1'b0, dl_wr[WR_STRETCH-1:1]};
	end

	assign ext_ram_wr = ioctl_download ? |dl_wr : (hard_reset ? clk_e : ~sam_we_n);

	// length is known once the last byte has gone
	always_ff @(posedge clk) begin
		if (ioctl_cart & ioctl_download & ~ioctl_wr)
			cart_q <= ioctl_addr > CART_MIN_SIZE;
		else if (cart_remove)
			cart_q <= 1'b0;
	end

	assign cart_loaded = cart_q;

	a_wr_stretch: assert property (@(posedge clk) disable iff (!reset_n)
		(ioctl_download && !ioctl_wr) [*WR_STRETCH+1] |-> !ext_ram_wr)
		else $error("download write held past the stretch");

endmodule

// ==== joystick_pad.sv ====
// d-pad to analog mapping, outputs one clock behind inputs and not reset
`timescale 1ns/10ps

module joystick_pad (
	input  logic                  clk,
	input  logic                  joy_use_dpad,
	input  logic [3:0]            joy1, // up, down, left, right
	input  logic [3:0]            joy2,
	input  dragon_pkg::joy_axis_t joya1,
	input  dragon_pkg::joy_axis_t joya2,
	output dragon_pkg::joy_axis_t dac_joya1,
	output dragon_pkg::joy_axis_t dac_joya2
);
	import dragon_pkg::*;

	// negative direction wins when both are pressed
	function automatic byte_t pad_axis(input logic neg, input logic pos);
		byte_t v;
		v = AXIS_MID;
		if (pos)
			v = AXIS_MAX;
		if (neg)
			v = AXIS_MIN;
		return v;
	endfunction

	always_ff @(posedge clk) begin
		if (joy_use_dpad) begin
			dac_joya1 <= {pad_axis(joy1[1], joy1[0]), pad_axis(joy1[3], joy1[2])};
			dac_joya2 <= {pad_axis(joy2[1], joy2[0]), pad_axis(joy2[3], joy2[2])};
		end else begin
			dac_joya1 <= joya1; // analog stick
			dac_joya2 <= joya2;
		end
	end

endmodule

// ==== tb_coco_glue.sv ====
// replays coco_glue_testdata.txt from the project root; read-back buses are fixed constants
`timescale 1ns/10ps

module tb_coco_glue;
	import dragon_pkg::*;

	logic clk;
	logic reset_n;
	logic dragon, mem64kb, cpu_rw, clk_e, ddrb2, portb2, sam_we_n;
	logic ioctl_download, ioctl_wr, ioctl_cart, ioctl_rom, hard_reset, cart_remove;
	logic disk_cart_enabled, fdc_irq, fdc_drq, joy_use_dpad;
	logic [15:0] cpu_addr, sam_a, joya1, joya2;
	logic [7:0] cpu_dout, ioctl_data;
	logic [16:0] ioctl_addr;
	logic [3:0] joy1, joy2;
	dev_sel_t device_select;
	logic [7:0] cpu_din, ext_ram_dout;
	logic [19:0] ext_rom_addr, ext_ram_addr;
	logic ext_rom_rd, pia_cs, pia1_cs, acia_cs, io_sel, ext_ram_wr, cart_loaded;
	logic fdc_sel, fdc_motor, fdc_dden, fdc_precomp, nmi, halt, ledb;
	logic [3:0] fdc_drive_sel;
	logic [15:0] dac_joya1, dac_joya2;
	logic [17:0] obits;

	// one entry per data line
	logic [31:0] vt[64], vcyc[64], vmode[64], vdsel[64], vaddr[64], vdout[64], vflags[64];
	logic [31:0] vioaddr[64], vjoy[64], vjoya[64], vchk[64], edin[64], erom[64], eram[64];
	logic [31:0] erdout[64], eflags[64], emask[64], edac1[64], edac2[64];
	int nvec = 0;
	int total_cycles = 0;
	bit loaded = 0;
	int errors = 0, checks = 0, test_errs = 0, test_checks = 0, tests_done = 0;

	coco_glue u_coco_glue (.*, .ext_rom_din(8'ha1), .ext_ram_din(8'hb2), .pia_dout(8'hc3),
		.pia1_dout(8'hd4), .acia_dout(8'he5), .fdc_dout(8'hf6));

	assign obits = {fdc_drive_sel, ledb, halt, nmi, fdc_precomp, fdc_dden, fdc_motor, fdc_sel,
		cart_loaded, ext_ram_wr, io_sel, acia_cs, pia1_cs, pia_cs, ext_rom_rd};

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		fd = $fopen("coco_glue_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open coco_glue_testdata.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && nvec < 64) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue; // blank or column notes
			n = $sscanf(line, "%h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				vt[nvec], vcyc[nvec], vmode[nvec], vdsel[nvec], vaddr[nvec], vdout[nvec],
				vflags[nvec], vioaddr[nvec], vjoy[nvec], vjoya[nvec], vchk[nvec], edin[nvec],
				erom[nvec], eram[nvec], erdout[nvec], eflags[nvec], emask[nvec],
				edac1[nvec], edac2[nvec]);
			if (n != 19) begin
				$display("malformed line in test data: %s", line);
				errors++;
				continue;
			end
			total_cycles += vcyc[nvec] + 1;
			nvec++;
		end
		$fclose(fd);
		if (nvec == 0) begin
			$display("test data holds no vectors");
			errors++;
		end
	endtask

	task automatic apply_vector(input int i);
		logic [31:0] f;
		f = vflags[i];
		dragon = vmode[i][1];
		mem64kb = vmode[i][0];
		device_select = dev_sel_t'(vdsel[i][2:0]);
		cpu_addr = vaddr[i][15:0];
		sam_a = vaddr[i][15:0];
		cpu_dout = vdout[i][7:0];
		ioctl_data = vdout[i][7:0];
		ioctl_addr = vioaddr[i][16:0];
		{joy2, joy1} = vjoy[i][7:0];
		joya1 = vjoya[i][15:0];
		joya2 = ~vjoya[i][15:0];
		{joy_use_dpad, ioctl_rom, ioctl_cart, ioctl_wr, ioctl_download} = f[14:10];
		{sam_we_n, cart_remove, hard_reset, fdc_drq, fdc_irq} = f[9:5];
		{disk_cart_enabled, portb2, ddrb2, cpu_rw, clk_e} = f[4:0];
	endtask

	task automatic compare_field(input int t, input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: test %0d %s is %h, expected %h", $time, t, what, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_vector(input int i);
		if (vchk[i][0]) compare_field(vt[i], "cpu_din", cpu_din, edin[i]);
		if (vchk[i][1]) compare_field(vt[i], "ext_rom_addr", ext_rom_addr, erom[i]);
		if (vchk[i][2]) compare_field(vt[i], "ext_ram_addr", ext_ram_addr, eram[i]);
		if (vchk[i][3]) compare_field(vt[i], "ext_ram_dout", ext_ram_dout, erdout[i]);
		if (vchk[i][4])
			compare_field(vt[i], "status bits", obits & emask[i], eflags[i] & emask[i]);
		if (vchk[i][5]) begin
			compare_field(vt[i], "dac_joya1", dac_joya1, edac1[i]);
			compare_field(vt[i], "dac_joya2", dac_joya2, edac2[i]);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d finished: %0d checks, %0d errors", t, test_checks, test_errs);
		tests_done++;
		test_checks = 0;
		test_errs = 0;
	endtask

	initial begin
		reset_n = 1'b0;
		{dragon, mem64kb, clk_e, ddrb2, portb2, hard_reset, cart_remove} = '0;
		{ioctl_download, ioctl_wr, ioctl_cart, ioctl_rom, joy_use_dpad} = '0;
		{disk_cart_enabled, fdc_irq, fdc_drq} = '0;
		{cpu_addr, sam_a, cpu_dout, ioctl_data, ioctl_addr, joy1, joy2, joya1, joya2} = '0;
		device_select = dev_ram;
		cpu_rw = 1'b1;
		sam_we_n = 1'b1;
		load_vectors();
		loaded = 1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		for (int i = 0; i < nvec; i++) begin
			if (i > 0 && vt[i] != vt[i-1])
				report_test(vt[i-1]);
			@(negedge clk);
			apply_vector(i);
			if (vcyc[i] != 0)
				repeat (vcyc[i]) @(posedge clk);
			#15; // settle before the next clock edge
			check_vector(i);
		end
		if (nvec > 0)
			report_test(vt[nvec-1]);
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the data file
	initial begin
		wait (loaded);
		#((total_cycles + 100) * 40);
		$display("timeout, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule
